//--- Makefile
# Verilator build and run of the 1x1 convolution testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= conv1x1Tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= ** FAIL **

.PHONY: sim clean

# A simulator that stops on an assertion leaves the fail message in the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
logic/convCfgPkg.sv
logic/convCtrlPkg.sv
logic/convLayerFsm.sv
logic/paramLoader.sv
logic/paramStore.sv
logic/macArray.sv
logic/requantOut.sv
logic/conv1x1Top.sv
verif/convLayer_asserts.sv
verif/conv1x1Tb.sv

//--- logic/conv1x1Top.sv
module conv1x1Top
    import convCfgPkg::*;
    import convCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  ctrlCode_t         control,
    input  logic              paramWe,
    input  logic [ParamW-1:0] paramData,
    input  logic              pixelValid,
    input  pixelIn_t          pixelData,
    output status_t           status,
    output logic              dmaReadValid,
    output logic              dmaWriteValid,
    output logic              layerDone,
    output logic              outValid,
    output pixelOut_t         outData
);

    logic                   loadStart;
    logic                   computeStart;
    logic                   paramDone;
    logic                   featDone;
    logic                   weightWe;
    logic                   biasWe;
    logic [WeightAddrW-1:0] paramAddr;
    weight_t                weightData;
    bias_t                  biasData;
    weight_t                weights [NumWeights];
    bias_t                  biases [NumOut];
    logic                   sumValid;
    acc_t                   sums [NumOut];

    convLayerFsm u_convLayerFsm (
        .clk           (clk),
        .rst           (rst),
        .control       (control),
        .paramDone     (paramDone),
        .featDone      (featDone),
        .status        (status),
        .loadStart     (loadStart),
        .computeStart  (computeStart),
        .dmaReadValid  (dmaReadValid),
        .dmaWriteValid (dmaWriteValid),
        .layerDone     (layerDone)
    );

    paramLoader u_paramLoader (
        .clk        (clk),
        .rst        (rst),
        .loadStart  (loadStart),
        .paramWe    (paramWe),
        .paramData  (paramData),
        .weightWe   (weightWe),
        .biasWe     (biasWe),
        .paramAddr  (paramAddr),
        .weightData (weightData),
        .biasData   (biasData),
        .paramDone  (paramDone)
    );

    paramStore #(.payload_t(weight_t), .Depth(NumWeights)) u_weightStore (
        .clk      (clk),
        .rst      (rst),
        .we       (weightWe),
        .addr     (paramAddr),
        .wrData   (weightData),
        .contents (weights)
    );

    paramStore #(.payload_t(bias_t), .Depth(NumOut)) u_biasStore (
        .clk      (clk),
        .rst      (rst),
        .we       (biasWe),
        .addr     (paramAddr[BiasAddrW-1:0]), // Bias store is shallower.
        .wrData   (biasData),
        .contents (biases)
    );

    macArray u_macArray (
        .clk        (clk),
        .rst        (rst),
        .pixelValid (pixelValid),
        .pixelData  (pixelData),
        .weights    (weights),
        .biases     (biases),
        .sumValid   (sumValid),
        .sums       (sums)
    );

    requantOut u_requantOut (
        .clk          (clk),
        .rst          (rst),
        .computeStart (computeStart),
        .sumValid     (sumValid),
        .sums         (sums),
        .outValid     (outValid),
        .outData      (outData),
        .featDone     (featDone)
    );

endmodule

//--- logic/convCfgPkg.sv
package convCfgPkg;

    // Layer shape.
    localparam int NumIn      = 4;
    localparam int NumOut     = 4;
    localparam int PixelCount = 8;                  // Pixels per compute phase.
    localparam int OutShift   = 6;
    localparam int NumWeights = NumIn * NumOut;
    localparam int NumParams  = NumWeights + NumOut; // Weights then biases.

    // Datapath widths.
    localparam int FeatW   = 8;
    localparam int WeightW = 8;
    localparam int BiasW   = 16;
    localparam int AccW    = 20;
    localparam int OutW    = 8;
    localparam int ParamW  = 16;                    // Width of the parameter strobe bus.
    localparam int OutMax  = (1 << OutW) - 1;

    localparam int WeightAddrW = $clog2(NumWeights);
    localparam int BiasAddrW   = $clog2(NumOut);
    localparam int ParamIdxW   = $clog2(NumParams);

    typedef logic signed [WeightW-1:0] weight_t;
    typedef logic signed [BiasW-1:0]   bias_t;
    typedef logic signed [FeatW-1:0]   feat_t;
    typedef feat_t [NumIn-1:0]         pixelIn_t;
    typedef logic signed [AccW-1:0]    acc_t;
    typedef logic [NumOut-1:0][OutW-1:0] pixelOut_t;

endpackage

//--- logic/convCtrlPkg.sv
package convCtrlPkg;

    typedef logic [3:0] ctrlCode_t;

    localparam ctrlCode_t CmdLoad    = 4'b0001;
    localparam ctrlCode_t CmdCompute = 4'b0010;
    localparam ctrlCode_t CmdAck     = 4'b1111;

    typedef enum logic [3:0] {
        IdleSt    = 4'b0000,
        ParaSt    = 4'b0001,
        ComputeSt = 4'b0010,
        ParaIrqSt = 4'b0011,
        FeatIrqSt = 4'b1111
    } layerState_t;

    typedef logic [3:0] status_t;

    // Both interrupt states report the same code to the host.
    localparam status_t StatusIdle    = 4'b0000;
    localparam status_t StatusPara    = 4'b0001;
    localparam status_t StatusCompute = 4'b0010;
    localparam status_t StatusIrq     = 4'b1111;

endpackage

//--- logic/convLayerFsm.sv
module convLayerFsm
    import convCtrlPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ctrlCode_t control,
    input  logic      paramDone,
    input  logic      featDone,
    output status_t   status,
    output logic      loadStart,
    output logic      computeStart,
    output logic      dmaReadValid,
    output logic      dmaWriteValid,
    output logic      layerDone
);

    layerState_t currentState;
    layerState_t nextState;

    logic enterPara;
    logic enterCompute;
    logic exitFeat;

    always_ff @(posedge clk) begin
        if (rst) begin
            currentState <= IdleSt;
        end else begin
            currentState <= nextState;
        end
    end

    always_comb begin
        nextState = currentState; // Hold on unexpected codes.
        case (currentState)
            IdleSt: begin
                if (control == CmdCompute) begin
                    nextState = ComputeSt;
                end else if (control == CmdLoad) begin
                    nextState = ParaSt;
                end
            end
            ParaSt: begin
                if (paramDone) begin
                    nextState = ParaIrqSt;
                end
            end
            ComputeSt: begin
                if (featDone) begin
                    nextState = FeatIrqSt;
                end
            end
            ParaIrqSt, FeatIrqSt: begin
                if (control == CmdAck) begin
                    nextState = IdleSt;
                end
            end
            default: nextState = IdleSt;
        endcase
    end

    assign enterPara    = (currentState == IdleSt) && (nextState == ParaSt);
    assign enterCompute = (currentState == IdleSt) && (nextState == ComputeSt);
    assign exitFeat     = (currentState == FeatIrqSt) && (nextState == IdleSt);

    // Pulses follow the transition by one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            loadStart     <= 1'b0;
            computeStart  <= 1'b0;
            dmaReadValid  <= 1'b0;
            dmaWriteValid <= 1'b0;
            layerDone     <= 1'b0;
        end else begin
            loadStart     <= enterPara;
            computeStart  <= enterCompute;
            dmaReadValid  <= enterPara || enterCompute;
            dmaWriteValid <= enterCompute; // Results go back out.
            layerDone     <= exitFeat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= StatusIdle;
        end else begin
            case (currentState)
                IdleSt:               status <= StatusIdle;
                ParaSt:               status <= StatusPara;
                ComputeSt:            status <= StatusCompute;
                ParaIrqSt, FeatIrqSt: status <= StatusIrq;
                default:              status <= StatusIdle;
            endcase
        end
    end

endmodule

//--- logic/macArray.sv
module macArray
    import convCfgPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     pixelValid,
    input  pixelIn_t pixelData,
    input  weight_t  weights [NumWeights],
    input  bias_t    biases [NumOut],
    output logic     sumValid,
    output acc_t     sums [NumOut]
);

    localparam int ProdW = FeatW + WeightW;

    logic signed [ProdW-1:0] prods [NumWeights];
    logic                    prodValid;
    acc_t                    sumNext [NumOut];

    // Stage one. Weight index is output * NumIn + input.
    always_ff @(posedge clk) begin
        for (int o = 0; o < NumOut; o++) begin
            for (int i = 0; i < NumIn; i++) begin
                prods[o*NumIn+i] <= $signed(pixelData[i]) * weights[o*NumIn+i];
            end
        end
    end

    always_comb begin
        for (int o = 0; o < NumOut; o++) begin
            sumNext[o] = acc_t'(biases[o]);
            for (int i = 0; i < NumIn; i++) begin
                sumNext[o] = sumNext[o] + acc_t'(prods[o*NumIn+i]);
            end
        end
    end

    // Stage two.
    always_ff @(posedge clk) begin
        for (int o = 0; o < NumOut; o++) begin
            sums[o] <= sumNext[o];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prodValid <= 1'b0;
            sumValid  <= 1'b0;
        end else begin
            prodValid <= pixelValid;
            sumValid  <= prodValid;
        end
    end

endmodule

//--- logic/paramLoader.sv
module paramLoader
    import convCfgPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   loadStart,
    input  logic                   paramWe,
    input  logic [ParamW-1:0]      paramData,
    output logic                   weightWe,
    output logic                   biasWe,
    output logic [WeightAddrW-1:0] paramAddr,
    output weight_t                weightData,
    output bias_t                  biasData,
    output logic                   paramDone
);

    localparam logic [ParamIdxW-1:0] LastIdx   = ParamIdxW'(NumParams - 1);
    localparam logic [ParamIdxW-1:0] BiasFirst = ParamIdxW'(NumWeights);

    logic                 armed;
    logic [ParamIdxW-1:0] paramIdx;
    logic                 accept;
    logic                 isBias;
    logic [ParamIdxW-1:0] storeIdx;

    assign accept = paramWe && armed;
    assign isBias = (paramIdx >= BiasFirst);

    // Biases restart at address zero in their own store.
    assign storeIdx  = isBias ? (paramIdx - BiasFirst) : paramIdx;
    assign paramAddr = storeIdx[WeightAddrW-1:0];

    assign weightWe   = accept && !isBias;
    assign biasWe     = accept && isBias;
    assign weightData = weight_t'(paramData[WeightW-1:0]); // Low byte only.
    assign biasData   = bias_t'(paramData);

    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            paramIdx  <= '0;
            paramDone <= 1'b0;
        end else begin
            paramDone <= 1'b0;
            if (loadStart) begin
                armed    <= 1'b1;
                paramIdx <= '0;
            end else if (accept) begin
                if (paramIdx == LastIdx) begin
                    armed     <= 1'b0;
                    paramIdx  <= '0;
                    paramDone <= 1'b1;
                end else begin
                    paramIdx <= paramIdx + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/paramStore.sv
module paramStore #(
    parameter type payload_t = logic [7:0],
    parameter int  Depth     = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(Depth)-1:0] addr,
    input  payload_t                 wrData,
    output payload_t                 contents [Depth]
);

    // Whole array is visible in parallel to the datapath.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                contents[i] <= '0;
            end
        end else if (we) begin
            contents[addr] <= wrData;
        end
    end

endmodule

//--- logic/requantOut.sv
module requantOut
    import convCfgPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      computeStart,
    input  logic      sumValid,
    input  acc_t      sums [NumOut],
    output logic      outValid,
    output pixelOut_t outData,
    output logic      featDone
);

    localparam int              CntW    = $clog2(PixelCount);
    localparam logic [CntW-1:0] LastPix = CntW'(PixelCount - 1);

    acc_t      shifted [NumOut];
    pixelOut_t nextData;
    logic      armed;
    logic [CntW-1:0] pixCnt;

    // ReLU, shift, then clamp to the output range.
    always_comb begin
        for (int c = 0; c < NumOut; c++) begin
            shifted[c] = sums[c] >>> OutShift;
            if (sums[c] < 0) begin
                nextData[c] = '0;
            end else if (shifted[c] > acc_t'(OutMax)) begin
                nextData[c] = OutW'(OutMax);
            end else begin
                nextData[c] = shifted[c][OutW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        outData <= nextData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            armed    <= 1'b0;
            pixCnt   <= '0;
            featDone <= 1'b0;
        end else begin
            outValid <= sumValid;
            featDone <= 1'b0;
            if (computeStart) begin
                armed  <= 1'b1;
                pixCnt <= '0;
            end else if (armed && outValid) begin
                if (pixCnt == LastPix) begin
                    armed    <= 1'b0;
                    pixCnt   <= '0;
                    featDone <= 1'b1; // Feature map finished.
                end else begin
                    pixCnt <= pixCnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- verif/conv1x1Tb.sv
module conv1x1Tb
    import convCfgPkg::*;
    import convCtrlPkg::*;
;

    localparam int        TableLen        = 9;
    localparam int        StatusWaitLimit = 50;
    localparam int        WatchdogCycles  = TableLen * (PixelCount + NumParams) * 20;
    localparam ctrlCode_t CtrlNone        = 4'b0000;
    localparam ctrlCode_t CtrlIllegal     = 4'b0101;

    typedef enum logic [1:0] {OpLoad, OpCompute, OpAck, OpIllegal} opKind_t;

    typedef struct packed {
        opKind_t op;
        logic    extreme;   // Fixed corner-case data instead of random.
        status_t expStatus;
        logic    expDone;
    } stepRow_t;

    logic              clk;
    logic              rst;
    ctrlCode_t         control;
    logic              paramWe;
    logic [ParamW-1:0] paramData;
    logic              pixelValid;
    pixelIn_t          pixelData;
    status_t           status;
    logic              dmaReadValid;
    logic              dmaWriteValid;
    logic              layerDone;
    logic              outValid;
    pixelOut_t         outData;

    stepRow_t    steps [TableLen];
    weight_t     weightRef [NumWeights];
    bias_t       biasRef [NumOut];
    logic [31:0] lfsrState;
    int          errCount;
    int          rowIdx;

    conv1x1Top u_conv1x1Top (
        .clk           (clk),
        .rst           (rst),
        .control       (control),
        .paramWe       (paramWe),
        .paramData     (paramData),
        .pixelValid    (pixelValid),
        .pixelData     (pixelData),
        .status        (status),
        .dmaReadValid  (dmaReadValid),
        .dmaWriteValid (dmaWriteValid),
        .layerDone     (layerDone),
        .outValid      (outValid),
        .outData       (outData)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1.
    function automatic logic nextRandBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[14:0], nextRandBit()};
        end
        return v;
    endfunction

    // Output rows go negative, in range, above cap and bias only.
    function automatic weight_t extremeWeight(input int idx);
        case (idx / NumIn)
            0:       return -8'sd1;
            1:       return 8'sd1;
            2:       return 8'sd127;
            default: return 8'sd0;
        endcase
    endfunction

    function automatic bias_t extremeBias(input int idx);
        case (idx)
            2:       return 16'sh7fff;
            3:       return 16'sd1000;
            default: return 16'sd0;
        endcase
    endfunction

    function automatic pixelOut_t modelPixel(input pixelIn_t px);
        pixelOut_t res;
        int        acc;
        int        scaled;
        for (int o = 0; o < NumOut; o++) begin
            acc = int'(biasRef[o]);
            for (int i = 0; i < NumIn; i++) begin
                acc += int'(weightRef[o*NumIn+i]) * int'($signed(px[i]));
            end
            if (acc < 0) begin
                res[o] = 8'd0;      // ReLU.
            end else begin
                scaled = acc / (1 << OutShift);
                res[o] = (scaled > 255) ? 8'd255 : scaled[7:0];
            end
        end
        return res;
    endfunction

    task automatic checkStatus(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("FAILED [row %0d] %s: expected %b, actual %b", rowIdx, name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkPixel(input string name, input pixelOut_t exp, input pixelOut_t act);
        if (act !== exp) begin
            $display("FAILED [row %0d] %s: expected %h, actual %h", rowIdx, name, exp, act);
            errCount++;
        end
    endtask

    task automatic checkPulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED [row %0d] %s: expected %b, actual %b", rowIdx, name, exp, act);
            errCount++;
        end
    endtask

    task automatic waitStatus(input string name, input status_t exp);
        int cycles;
        cycles = 0;
        while (status !== exp && cycles < StatusWaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (status !== exp) begin
            $display("Row %0d %s: status never reached %b within %0d cycles",
                     rowIdx, name, exp, StatusWaitLimit);
            errCount++;
        end
    endtask

    task automatic loadParams(input logic extreme);
        logic [15:0] rb;
        int          j;
        @(negedge clk);
        control = CmdLoad;
        @(negedge clk);
        checkPulse("load dmaReadValid", 1'b1, dmaReadValid);
        checkPulse("load dmaWriteValid", 1'b0, dmaWriteValid);
        control = CmdCompute;   // Must be ignored while loading.
        @(negedge clk);
        checkStatus("load status", StatusPara, status);
        for (int p = 0; p < NumParams; p++) begin
            if (p < NumWeights) begin
                weightRef[p] = extreme ? extremeWeight(p) : weight_t'(randBits(8));
                paramData = {8'ha5, weightRef[p]}; // Upper byte is junk.
            end else begin
                j = p - NumWeights;
                rb = randBits(12);
                biasRef[j] = extreme ? extremeBias(j) : bias_t'($signed(rb[11:0]));
                paramData = biasRef[j];
            end
            paramWe = 1'b1;
            @(negedge clk);
            checkStatus("status while loading", StatusPara, status);
            checkPulse("no new phase while loading", 1'b0, dmaReadValid);
        end
        paramWe = 1'b0;
        control = CtrlNone;
    endtask

    task automatic runCompute(input logic extreme);
        pixelIn_t  px;
        pixelOut_t expQ [PixelCount];
        @(negedge clk);
        control = CmdCompute;
        @(negedge clk);
        checkPulse("compute dmaReadValid", 1'b1, dmaReadValid);
        checkPulse("compute dmaWriteValid", 1'b1, dmaWriteValid);
        control = CtrlNone;
        @(negedge clk);
        checkStatus("compute status", StatusCompute, status);
        // Pixel n driven at this edge shows up three cycles later.
        for (int n = 0; n < PixelCount + 3; n++) begin
            if (n >= 3) begin
                checkPulse("outValid", 1'b1, outValid);
                checkPixel($sformatf("pixel %0d", n - 3), expQ[n-3], outData);
            end else begin
                checkPulse("outValid before first result", 1'b0, outValid);
            end
            if (n < PixelCount) begin
                for (int c = 0; c < NumIn; c++) begin
                    px[c] = extreme ? feat_t'(100 + n) : feat_t'(randBits(8));
                end
                expQ[n] = modelPixel(px);
                pixelValid = 1'b1;
                pixelData = px;
            end else begin
                pixelValid = 1'b0;
            end
            @(negedge clk);
        end
        checkPulse("outValid after last result", 1'b0, outValid);
    endtask

    task automatic sendAck(input logic expDone);
        @(negedge clk);
        control = CmdAck;
        @(negedge clk);
        checkPulse("layerDone on ack", expDone, layerDone);
        control = CtrlNone;
        @(negedge clk);
        checkPulse("layerDone single pulse", 1'b0, layerDone);
    endtask

    task automatic holdOnIllegal();
        @(negedge clk);
        control = CtrlIllegal;
        repeat (3) begin
            @(negedge clk);
            checkStatus("idle hold on illegal code", StatusIdle, status);
            checkPulse("no dma on illegal code", 1'b0, dmaReadValid);
        end
        control = CtrlNone;
    endtask

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", WatchdogCycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        errCount   = 0;
        rowIdx     = -1;
        lfsrState  = 32'h3f37;
        rst        = 1'b1;
        control    = CtrlNone;
        paramWe    = 1'b0;
        paramData  = '0;
        pixelValid = 1'b0;
        pixelData  = '0;

        steps[0] = '{OpIllegal, 1'b0, StatusIdle, 1'b0};
        steps[1] = '{OpLoad,    1'b0, StatusIrq,  1'b0};
        steps[2] = '{OpAck,     1'b0, StatusIdle, 1'b0};
        steps[3] = '{OpCompute, 1'b0, StatusIrq,  1'b0};
        steps[4] = '{OpAck,     1'b0, StatusIdle, 1'b1};
        steps[5] = '{OpLoad,    1'b1, StatusIrq,  1'b0};
        steps[6] = '{OpAck,     1'b0, StatusIdle, 1'b0};
        steps[7] = '{OpCompute, 1'b1, StatusIrq,  1'b0};
        steps[8] = '{OpAck,     1'b0, StatusIdle, 1'b1};

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkStatus("status after reset", StatusIdle, status);
        checkPulse("outValid after reset", 1'b0, outValid);
        checkPulse("dmaReadValid after reset", 1'b0, dmaReadValid);
        checkPulse("dmaWriteValid after reset", 1'b0, dmaWriteValid);
        checkPulse("layerDone after reset", 1'b0, layerDone);

        for (int r = 0; r < TableLen; r++) begin
            rowIdx = r;
            case (steps[r].op)
                OpLoad:    loadParams(steps[r].extreme);
                OpCompute: runCompute(steps[r].extreme);
                OpAck:     sendAck(steps[r].expDone);
                default:   holdOnIllegal();
            endcase
            waitStatus("status at end of row", steps[r].expStatus);
        end

        $display("Checks finished with %0d errors", errCount);
        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verif/convLayer_asserts.sv
module convLayerAsserts
    import convCtrlPkg::*;
(
    input logic    clk,
    input logic    rst,
    input status_t status,
    input logic    loadStart,
    input logic    computeStart,
    input logic    dmaReadValid,
    input logic    dmaWriteValid,
    input logic    layerDone
);

    // Only one phase can start at a time.
    assert property (@(posedge clk) disable iff (rst) !(loadStart && computeStart))
        else $error("loadStart and computeStart are high in the same cycle");

    assert property (@(posedge clk) disable iff (rst) dmaWriteValid |-> dmaReadValid)
        else $error("dmaWriteValid is high without dmaReadValid");

    // Status still shows the interrupt while done pulses.
    assert property (@(posedge clk) disable iff (rst) layerDone |-> status == StatusIrq)
        else $error("layerDone pulsed while status was not the interrupt code");

endmodule

bind convLayerFsm convLayerAsserts u_convLayerAsserts (
    .clk           (clk),
    .rst           (rst),
    .status        (status),
    .loadStart     (loadStart),
    .computeStart  (computeStart),
    .dmaReadValid  (dmaReadValid),
    .dmaWriteValid (dmaWriteValid),
    .layerDone     (layerDone)
);
